// File: tests/pipe_tests.txt
// Each pair has an even and an odd pixel as RRRGGGBBB
// then the even and odd expected words as YYYCCC00F with F the Cr flag
800800800
400400400
7DE800000
46F800001
400000000
000000400
207895000
1648BC001
000400000
123456789
30485B000
436672001
FFFFFFFFF
000000000
EBB800000
100800001
FFF000000
000FFFFFF
51B7FF000
A9F7FF001
ABC3210F0
0509A03C0
56C65A000
64B7E9001

// File: build.f
common/videoPkg.sv
common/colorPkg.sv
common/ycbcrIf.sv
colorConvert/macTriple.sv
colorConvert/rgbToYCbCr.sv
src/pixelFifo.sv
src/chromaSubsampler.sv
src/videoPipeTop.sv
tests/videoPipe_chk.sv
tests/videoPipeTb.sv

// File: Bender.yml
package:
  name: video_pipe

sources:
  # Packages and interfaces ahead of the modules that use them
  - common/videoPkg.sv
  - common/colorPkg.sv
  - common/ycbcrIf.sv
  - colorConvert/macTriple.sv
  - colorConvert/rgbToYCbCr.sv
  - src/pixelFifo.sv
  - src/chromaSubsampler.sv
  - src/videoPipeTop.sv
  - target: test
    files:
      - tests/videoPipe_chk.sv
      - tests/videoPipeTb.sv

// File: tests/videoPipeTb.sv
`timescale 1ns/1ps

module videoPipeTb;

  localparam int NUM_PAIRS = 6;
  localparam int NUM_PIX = NUM_PAIRS * 2;
  // Two pixels and two expected words per pair
  localparam int MEM_WORDS = NUM_PAIRS * 4;
  localparam int OVF_PIX = 20;
  localparam int OVF_KEPT = videoPkg::FIFO_DEPTH;
  localparam int WATCHDOG_CYCLES = (NUM_PIX + OVF_PIX) * 20 + 200;
  localparam int SEED = 87527;
  // FIFO level never exceeds pixels sent but not yet seen at the output
  localparam int FORCE_LEVEL = 10;
  localparam int EN_LOW = 0;
  localparam int EN_HIGH = 1;
  localparam int EN_RANDOM = 2;

  logic iCLK = 1'b0;
  logic iRESET;
  logic [videoPkg::PIX_W-1:0] iRed;
  logic [videoPkg::PIX_W-1:0] iGreen;
  logic [videoPkg::PIX_W-1:0] iBlue;
  logic iDVAL;
  logic iOutEnable;
  logic [videoPkg::PIX_W-1:0] oY;
  logic [videoPkg::PIX_W-1:0] oC;
  logic oDVAL;
  logic oChromaIsCr;
  logic oOverflow;

  logic [35:0] testMem [MEM_WORDS];
  logic [35:0] expQ [$];
  logic [35:0] expWord;
  int sentCount = 0;
  int outCount = 0;
  int valueErrors = 0;
  int otherErrors = 0;

  videoPipeTop UUT
  (
    .iCLK        (iCLK),
    .iRESET      (iRESET),
    .iRed        (iRed),
    .iGreen      (iGreen),
    .iBlue       (iBlue),
    .iDVAL       (iDVAL),
    .iOutEnable  (iOutEnable),
    .oY          (oY),
    .oC          (oC),
    .oDVAL       (oDVAL),
    .oChromaIsCr (oChromaIsCr),
    .oOverflow   (oOverflow)
  );

  always #5 iCLK = ~iCLK;

  // Pixel p of the list, even pixel first within its pair
  function automatic logic [35:0] pixelWord(input int p);
    return testMem[(p / 2) * 4 + (p % 2)];
  endfunction

  task automatic queuePairs(input int numPairs);
    int pair;
    for (int k = 0; k < numPairs; k++)
    begin
      pair = k % NUM_PAIRS;
      expQ.push_back(testMem[pair * 4 + 2]);
      expQ.push_back(testMem[pair * 4 + 3]);
    end
  endtask

  task automatic checkValue
  (
    input string name,
    input logic [11:0] expected,
    input logic [11:0] actual
  );
    if (actual !== expected)
    begin
      $display("ERROR %s word %0d: expected %h, got %h", name, outCount, expected, actual);
      valueErrors++;
    end
  endtask

  // One clock of input, enable low, high or randomly toggled
  task automatic stepCycle(input logic dval, input logic [35:0] rgb, input int enMode);
    @(posedge iCLK);
    iDVAL <= dval;
    iRed <= rgb[35:24];
    iGreen <= rgb[23:12];
    iBlue <= rgb[11:0];
    if (enMode == EN_LOW)
      iOutEnable <= 1'b0;
    else if (enMode == EN_HIGH || sentCount - outCount >= FORCE_LEVEL)
      iOutEnable <= 1'b1;
    else if ($urandom % 3 == 0)
      iOutEnable <= !iOutEnable;
    if (dval)
      sentCount++;
  endtask

  task automatic waitForOutputs(input int target);
    while (outCount < target)
      @(posedge iCLK);
  endtask

  task automatic checkAfterReset();
    repeat (3)
      stepCycle(1'b0, '0, EN_HIGH);
    @(negedge iCLK);
    if (oDVAL !== 1'b0)
    begin
      $display("ERROR oDVAL after reset: expected %h, got %h", 1'b0, oDVAL);
      valueErrors++;
    end
    if (oOverflow !== 1'b0)
    begin
      $display("ERROR oOverflow after reset: expected %h, got %h", 1'b0, oOverflow);
      valueErrors++;
    end
    if (UUT.fifoRead.empty !== 1'b1)
    begin
      $display("ERROR empty after reset: expected %h, got %h", 1'b1, UUT.fifoRead.empty);
      valueErrors++;
    end
  endtask

  // Random gaps and enable pauses, back-to-back pixels when the gap is zero
  task automatic runMainPhase();
    int gap;
    queuePairs(NUM_PAIRS);
    for (int p = 0; p < NUM_PIX; p++)
    begin
      gap = $urandom % 4;
      repeat (gap)
        stepCycle(1'b0, '0, EN_RANDOM);
      stepCycle(1'b1, pixelWord(p), EN_RANDOM);
    end
    stepCycle(1'b0, '0, EN_HIGH);
    waitForOutputs(NUM_PIX);
  endtask

  task automatic runOverflowPhase();
    @(negedge iCLK);
    if (oOverflow !== 1'b0)
    begin
      $display("ERROR oOverflow before overflow phase: expected %h, got %h", 1'b0, oOverflow);
      valueErrors++;
    end
    // Only the first FIFO_DEPTH pixels fit, the rest are dropped
    queuePairs(OVF_KEPT / 2);
    for (int p = 0; p < OVF_PIX; p++)
      stepCycle(1'b1, pixelWord(p % NUM_PIX), EN_LOW);
    // Last pixel still inside the five-stage converter
    repeat (8)
      stepCycle(1'b0, '0, EN_LOW);
    @(negedge iCLK);
    if (oOverflow !== 1'b1)
    begin
      $display("ERROR oOverflow after 20 pixels: expected %h, got %h", 1'b1, oOverflow);
      valueErrors++;
    end
    if (outCount != NUM_PIX)
    begin
      $display("Output words appeared while iOutEnable was held low");
      otherErrors++;
    end
    stepCycle(1'b0, '0, EN_HIGH);
    waitForOutputs(NUM_PIX + OVF_KEPT);
    repeat (10)
      stepCycle(1'b0, '0, EN_HIGH);
    @(negedge iCLK);
    if (outCount != NUM_PIX + OVF_KEPT || expQ.size() != 0)
    begin
      $display("Overflow phase gave %0d output words, %0d were expected",
               outCount - NUM_PIX, OVF_KEPT);
      otherErrors++;
    end
  endtask

  // Scoreboard, outputs are stable at the falling edge
  always @(negedge iCLK)
  begin
    if (!iRESET && oDVAL === 1'b1)
    begin
      if (sentCount == 0)
      begin
        $display("Output strobe appeared before any input pixel");
        otherErrors++;
      end
      else if (expQ.size() == 0)
      begin
        $display("Output word %0d arrived with no expected word left", outCount);
        otherErrors++;
      end
      else
      begin
        expWord = expQ.pop_front();
        checkValue("oY", expWord[35:24], oY);
        checkValue("oC", expWord[23:12], oC);
        checkValue("oChromaIsCr", expWord[11:0], {11'b0, oChromaIsCr});
      end
      outCount++;
    end
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES)
      @(posedge iCLK);
    $display("Watchdog expired after %0d cycles with outputs still missing", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  initial
  begin
    iRESET <= 1'b1;
    iDVAL <= 1'b0;
    iOutEnable <= 1'b0;
    iRed <= '0;
    iGreen <= '0;
    iBlue <= '0;
    void'($urandom(SEED));
    $readmemh("tests/pipe_tests.txt", testMem);
    if ($isunknown(testMem[MEM_WORDS-1]))
    begin
      $display("Stimulus file tests/pipe_tests.txt is missing or too short");
      otherErrors++;
    end
    repeat (4)
      @(posedge iCLK);
    iRESET <= 1'b0;
    checkAfterReset();
    runMainPhase();
    runOverflowPhase();
    $display("Run complete with %0d value errors, %0d other errors and %0d assertion failures",
             valueErrors, otherErrors, UUT.pipeChk.failCount);
    if (valueErrors + otherErrors + UUT.pipeChk.failCount == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: tests/videoPipe_chk.sv
`timescale 1ns/1ps

module videoPipe_chk
(
  input logic iCLK,
  input logic iRESET,
  input logic rdEn,
  input logic empty,
  input logic [videoPkg::FIFO_CNT_W-1:0] count,
  input logic oDVAL,
  input logic oChromaIsCr,
  input logic oOverflow
);

  // Number of assertion failures so far
  int failCount = 0;

  // Subsampler must never pop an empty FIFO
  rdEnNotEmpty: assert property (@(posedge iCLK) disable iff (iRESET) !(rdEn && empty))
    else
    begin
      $error("FIFO read enable high while empty");
      failCount++;
    end

  fifoCountRange: assert property (@(posedge iCLK) disable iff (iRESET)
    count <= videoPkg::FIFO_CNT_W'(videoPkg::FIFO_DEPTH))
    else
    begin
      $error("FIFO count above depth");
      failCount++;
    end

  // Cb word is always followed by its Cr word
  cbThenCr: assert property (@(posedge iCLK) disable iff (iRESET)
    (oDVAL && !oChromaIsCr) |=> (oDVAL && oChromaIsCr))
    else
    begin
      $error("Cb output word not followed by a Cr word");
      failCount++;
    end

  crEndsPair: assert property (@(posedge iCLK) disable iff (iRESET)
    (oDVAL && oChromaIsCr) |=> !(oDVAL && oChromaIsCr))
    else
    begin
      $error("Two Cr output words in a row");
      failCount++;
    end

  overflowSticky: assert property (@(posedge iCLK) disable iff (iRESET) !$fell(oOverflow))
    else
    begin
      $error("Overflow flag cleared without reset");
      failCount++;
    end

endmodule

// FIFO read port and subsampler outputs both meet at the top level
bind videoPipeTop videoPipe_chk pipeChk
(
  .iCLK        (iCLK),
  .iRESET      (iRESET),
  .rdEn        (fifoRead.rdEn),
  .empty       (fifoRead.empty),
  .count       (fifoRead.count),
  .oDVAL       (oDVAL),
  .oChromaIsCr (oChromaIsCr),
  .oOverflow   (oOverflow)
);

// File: src/videoPipeTop.sv
`timescale 1ns/1ps

module videoPipeTop
(
  input  logic iCLK,
  input  logic iRESET,
  input  logic [videoPkg::PIX_W-1:0] iRed,
  input  logic [videoPkg::PIX_W-1:0] iGreen,
  input  logic [videoPkg::PIX_W-1:0] iBlue,
  input  logic iDVAL,
  input  logic iOutEnable,
  output logic [videoPkg::PIX_W-1:0] oY,
  output logic [videoPkg::PIX_W-1:0] oC,
  output logic oDVAL,
  output logic oChromaIsCr,
  output logic oOverflow
);

  pixelStreamIf convStream ();
  fifoReadIf fifoRead ();

  // Fixed-coefficient colour conversion, five-cycle pipeline
  rgbToYCbCr converter
  (
    .iCLK      (iCLK),
    .iRESET    (iRESET),
    .iRed      (iRed),
    .iGreen    (iGreen),
    .iBlue     (iBlue),
    .iDVAL     (iDVAL),
    .outStream (convStream.src)
  );

  pixelFifo fifo
  (
    .iCLK      (iCLK),
    .iRESET    (iRESET),
    .inStream  (convStream.snk),
    .readPort  (fifoRead.fifo),
    .oOverflow (oOverflow)
  );

  // 4:2:2 output, one Y and one chroma sample per strobe
  chromaSubsampler subsampler
  (
    .iCLK        (iCLK),
    .iRESET      (iRESET),
    .iOutEnable  (iOutEnable),
    .readPort    (fifoRead.reader),
    .oY          (oY),
    .oC          (oC),
    .oDVAL       (oDVAL),
    .oChromaIsCr (oChromaIsCr)
  );

endmodule

// File: src/chromaSubsampler.sv
`timescale 1ns/1ps

module chromaSubsampler
(
  input  logic iCLK,
  input  logic iRESET,
  input  logic iOutEnable,
  fifoReadIf.reader readPort,
  output logic [videoPkg::PIX_W-1:0] oY,
  output logic [videoPkg::PIX_W-1:0] oC,
  output logic oDVAL,
  output logic oChromaIsCr
);

  videoPkg::phaseT phase;
  videoPkg::phaseT nextPhase;
  logic startPair;
  logic popEven;
  logic popOdd;
  // Odd word still to go out on the next cycle
  logic crPending;
  videoPkg::pixelT evenPix;
  logic [videoPkg::PIX_W-1:0] oddY;
  logic [videoPkg::PIX_W-1:0] crHeld;
  logic [videoPkg::PIX_W:0] cbSum;
  logic [videoPkg::PIX_W:0] crSum;

  // Enable is sampled only here, a started pair always finishes
  assign startPair = (readPort.count >= videoPkg::FIFO_CNT_W'(2)) && iOutEnable;
  assign popEven = (phase == videoPkg::PH_EVEN) && startPair;
  assign popOdd  = (phase == videoPkg::PH_ODD);
  assign readPort.rdEn = popEven || popOdd;

  always_comb
  begin
    nextPhase = phase;
    if (popEven)
      nextPhase = videoPkg::PH_ODD;
    else if (popOdd)
      nextPhase = videoPkg::PH_EVEN;
  end

  // Floor average keeps the top bits of the sum
  assign cbSum = {1'b0, evenPix.cb} + {1'b0, readPort.rdData.cb};
  assign crSum = {1'b0, evenPix.cr} + {1'b0, readPort.rdData.cr};

  always_ff @(posedge iCLK)
  begin
    if (iRESET)
    begin
      phase <= videoPkg::PH_EVEN;
      oDVAL <= 1'b0;
      oChromaIsCr <= 1'b0;
      crPending <= 1'b0;
    end
    else
    begin
      phase <= nextPhase;
      if (popOdd)
      begin
        oDVAL <= 1'b1;
        oChromaIsCr <= 1'b0;
        crPending <= 1'b1;
      end
      else if (crPending)
      begin
        oDVAL <= 1'b1;
        oChromaIsCr <= 1'b1;
        crPending <= 1'b0;
      end
      else
        oDVAL <= 1'b0;
    end
  end

  always_ff @(posedge iCLK)
  begin
    if (popEven)
      evenPix <= readPort.rdData;

    if (popOdd)
    begin
      // Even word, Y of the first pixel with the Cb average
      oY <= evenPix.y;
      oC <= cbSum[videoPkg::PIX_W:1];
      oddY <= readPort.rdData.y;
      crHeld <= crSum[videoPkg::PIX_W:1];
    end
    else if (crPending)
    begin
      oY <= oddY;
      oC <= crHeld;
    end
  end

endmodule

// File: src/pixelFifo.sv
`timescale 1ns/1ps

module pixelFifo
(
  input  logic iCLK,
  input  logic iRESET,
  pixelStreamIf.snk inStream,
  fifoReadIf.fifo readPort,
  output logic oOverflow
);

  videoPkg::pixelT mem [videoPkg::FIFO_DEPTH];
  logic [videoPkg::FIFO_AW-1:0] wrPtr;
  logic [videoPkg::FIFO_AW-1:0] rdPtr;
  logic [videoPkg::FIFO_CNT_W-1:0] count;
  logic full;
  logic wrAccept;
  logic rdAccept;

  assign full = (count == videoPkg::FIFO_CNT_W'(videoPkg::FIFO_DEPTH));
  // A full FIFO drops the write even if a read happens in the same cycle
  assign wrAccept = inStream.dval && !full;
  assign rdAccept = readPort.rdEn && (count != '0);

  // Storage needs no reset, pointers and count cover validity
  always_ff @(posedge iCLK)
  begin
    if (wrAccept)
      mem[wrPtr] <= inStream.pix;
  end

  always_ff @(posedge iCLK)
  begin
    if (iRESET)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
      oOverflow <= 1'b0;
    end
    else
    begin
      if (wrAccept)
        wrPtr <= wrPtr + 1'b1;
      if (rdAccept)
        rdPtr <= rdPtr + 1'b1;

      case ({wrAccept, rdAccept})
        2'b10:
          count <= count + 1'b1;
        2'b01:
          count <= count - 1'b1;
        default:
          count <= count;
      endcase

      // Sticky until reset
      if (inStream.dval && full)
        oOverflow <= 1'b1;
    end
  end

  // Head entry is visible without a read cycle
  assign readPort.rdData = mem[rdPtr];
  assign readPort.empty  = (count == '0);
  assign readPort.count  = count;

endmodule

// File: colorConvert/rgbToYCbCr.sv
`timescale 1ns/1ps

module rgbToYCbCr
(
  input  logic iCLK,
  input  logic iRESET,
  input  logic [videoPkg::PIX_W-1:0] iRed,
  input  logic [videoPkg::PIX_W-1:0] iGreen,
  input  logic [videoPkg::PIX_W-1:0] iBlue,
  input  logic iDVAL,
  pixelStreamIf.src outStream
);

  logic signed [colorPkg::MAC_W-1:0] macY, macCr, macCb;
  logic signed [colorPkg::MAC_W:0] offY, offCr, offCb;
  logic [colorPkg::SHIFT_W-1:0] shY, shCr, shCb;
  videoPkg::pixelT clampPix;
  // Three MAC stages, shift stage, clamp stage
  logic [4:0] dvalPipe;

  // Negative goes to zero, anything above the channel range saturates
  function automatic logic [videoPkg::PIX_W-1:0] clampChannel
  (
    input logic [colorPkg::SHIFT_W-1:0] v
  );
    if (v[colorPkg::SHIFT_W-1])
      return '0;
    else if (v[colorPkg::SHIFT_W-2:0] > colorPkg::CLAMP_MAX)
      return colorPkg::CLAMP_MAX;
    else
      return v[videoPkg::PIX_W-1:0];
  endfunction

  macTriple yMac
  (
    .iCLK   (iCLK),
    .iRESET (iRESET),
    .a0     (iRed),
    .a1     (iGreen),
    .a2     (iBlue),
    .b0     (colorPkg::Y_R),
    .b1     (colorPkg::Y_G),
    .b2     (colorPkg::Y_B),
    .result (macY)
  );

  macTriple crMac
  (
    .iCLK   (iCLK),
    .iRESET (iRESET),
    .a0     (iRed),
    .a1     (iGreen),
    .a2     (iBlue),
    .b0     (colorPkg::CR_R),
    .b1     (colorPkg::CR_G),
    .b2     (colorPkg::CR_B),
    .result (macCr)
  );

  macTriple cbMac
  (
    .iCLK   (iCLK),
    .iRESET (iRESET),
    .a0     (iRed),
    .a1     (iGreen),
    .a2     (iBlue),
    .b0     (colorPkg::CB_R),
    .b1     (colorPkg::CB_G),
    .b2     (colorPkg::CB_B),
    .result (macCb)
  );

  // Sign-extend by one bit so the offset add cannot wrap
  assign offY  = {macY[colorPkg::MAC_W-1], macY} + colorPkg::Y_OFFSET;
  assign offCr = {macCr[colorPkg::MAC_W-1], macCr} + colorPkg::C_OFFSET;
  assign offCb = {macCb[colorPkg::MAC_W-1], macCb} + colorPkg::C_OFFSET;

  always_ff @(posedge iCLK)
  begin
    // Dropping the low bits is the arithmetic shift
    shY  <= offY[colorPkg::MAC_W:colorPkg::FRAC_SHIFT];
    shCr <= offCr[colorPkg::MAC_W:colorPkg::FRAC_SHIFT];
    shCb <= offCb[colorPkg::MAC_W:colorPkg::FRAC_SHIFT];
    clampPix.y  <= clampChannel(shY);
    clampPix.cr <= clampChannel(shCr);
    clampPix.cb <= clampChannel(shCb);
  end

  always_ff @(posedge iCLK)
  begin
    if (iRESET)
      dvalPipe <= '0;
    else
      dvalPipe <= {dvalPipe[3:0], iDVAL};
  end

  assign outStream.pix  = clampPix;
  assign outStream.dval = dvalPipe[4];

endmodule

// File: colorConvert/macTriple.sv
`timescale 1ns/1ps

module macTriple
(
  input  logic iCLK,
  input  logic iRESET,
  input  logic [videoPkg::PIX_W-1:0] a0,
  input  logic [videoPkg::PIX_W-1:0] a1,
  input  logic [videoPkg::PIX_W-1:0] a2,
  input  logic signed [colorPkg::COEF_W-1:0] b0,
  input  logic signed [colorPkg::COEF_W-1:0] b1,
  input  logic signed [colorPkg::COEF_W-1:0] b2,
  output logic signed [colorPkg::MAC_W-1:0] result
);

  logic [videoPkg::PIX_W-1:0] a0Reg, a1Reg, a2Reg;
  logic signed [colorPkg::COEF_W-1:0] b0Reg, b1Reg, b2Reg;
  logic signed [colorPkg::MAC_W-1:0] prod0, prod1, prod2;

  always_ff @(posedge iCLK)
  begin
    if (iRESET)
    begin
      a0Reg <= '0;
      a1Reg <= '0;
      a2Reg <= '0;
      b0Reg <= '0;
      b1Reg <= '0;
      b2Reg <= '0;
      prod0 <= '0;
      prod1 <= '0;
      prod2 <= '0;
      result <= '0;
    end
    else
    begin
      // Stage 1 operand capture
      a0Reg <= a0;
      a1Reg <= a1;
      a2Reg <= a2;
      b0Reg <= b0;
      b1Reg <= b1;
      b2Reg <= b2;
      // Stage 2, pixels are unsigned so a zero sign bit goes in front
      prod0 <= $signed({1'b0, a0Reg}) * b0Reg;
      prod1 <= $signed({1'b0, a1Reg}) * b1Reg;
      prod2 <= $signed({1'b0, a2Reg}) * b2Reg;
      // Stage 3 sum
      result <= prod0 + prod1 + prod2;
    end
  end

endmodule

// File: common/ycbcrIf.sv
`timescale 1ns/1ps

// Converted pixel stream, one strobe per pixel and no back-pressure
interface pixelStreamIf;

  videoPkg::pixelT pix;
  logic dval;

  modport src
  (
    output pix,
    output dval
  );

  modport snk
  (
    input pix,
    input dval
  );

endinterface

// FIFO read side, head entry shown while not empty
interface fifoReadIf;

  logic rdEn;
  videoPkg::pixelT rdData;
  logic empty;
  logic [videoPkg::FIFO_CNT_W-1:0] count;

  modport fifo
  (
    input rdEn,
    output rdData,
    output empty,
    output count
  );

  modport reader
  (
    output rdEn,
    input rdData,
    input empty,
    input count
  );

endinterface

// File: common/colorPkg.sv
package colorPkg;

  localparam int COEF_W = 12;
  localparam int MAC_W = 26;
  localparam int FRAC_SHIFT = 10;
  // Width after offset add and shift, sign bit included
  localparam int SHIFT_W = MAC_W + 1 - FRAC_SHIFT;

  // Y row, all positive
  localparam logic signed [COEF_W-1:0] Y_R = 12'sh107;
  localparam logic signed [COEF_W-1:0] Y_G = 12'sh204;
  localparam logic signed [COEF_W-1:0] Y_B = 12'sh064;

  // Cr row
  localparam logic signed [COEF_W-1:0] CR_R = 12'sh1C2;
  localparam logic signed [COEF_W-1:0] CR_G = 12'shE87;
  localparam logic signed [COEF_W-1:0] CR_B = 12'shFB7;

  // Cb row
  localparam logic signed [COEF_W-1:0] CB_R = 12'shF68;
  localparam logic signed [COEF_W-1:0] CB_G = 12'shED6;
  localparam logic signed [COEF_W-1:0] CB_B = 12'sh1C2;

  // Offsets added before the shift, luma black level and chroma midpoint
  localparam logic signed [MAC_W:0] Y_OFFSET = 27'sd262144;
  localparam logic signed [MAC_W:0] C_OFFSET = 27'sd2097152;

  localparam logic [videoPkg::PIX_W-1:0] CLAMP_MAX = 12'd4095;

endpackage

// File: common/videoPkg.sv
package videoPkg;

  // Channel width of camera and converted pixels
  localparam int PIX_W = 12;

  // Pixel buffer between converter and subsampler
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_AW = 4;
  // Occupancy needs one more bit than the address
  localparam int FIFO_CNT_W = FIFO_AW + 1;

  // Position within a pixel pair
  typedef enum logic
  {
    PH_EVEN,
    PH_ODD
  } phaseT;

  // One converted pixel, 36 bits
  typedef struct packed
  {
    logic [PIX_W-1:0] y;
    logic [PIX_W-1:0] cb;
    logic [PIX_W-1:0] cr;
  } pixelT;

endpackage
